// File: source/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  // ======================================================================
  // 640x480 at 60 Hz mode timing
  // ======================================================================
  localparam int h_active = 640;
  localparam int h_front = 16;
  localparam int h_sync = 96;
  localparam int h_back = 48;
  localparam int h_total = h_active + h_front + h_sync + h_back; // 800

  localparam int v_active = 480;
  localparam int v_front = 10;
  localparam int v_sync = 2;
  localparam int v_back = 33;
  localparam int v_total = v_active + v_front + v_sync + v_back; // 525

  // ======================================================================
  // Framebuffer geometry and widths
  // ======================================================================
  localparam int num_stripes = 2;
  localparam int fb_words = h_active * v_active;
  localparam int sram_addr_width = 20;
  localparam int color_width = 4;
  localparam int pixel_width = 3 * color_width;
  localparam int coord_width = 10;  // Holds h and v counts up to 799
  localparam int index_width = 19;  // Linear pixel index

  // Register map
  localparam logic [7:0] reg_ctrl = 8'h00;
  localparam logic [7:0] reg_color_a = 8'h04;
  localparam logic [7:0] reg_color_b = 8'h08;
  localparam logic [7:0] reg_stripe_log2 = 8'h0C;
  localparam logic [7:0] reg_status = 8'h10;

  typedef struct packed {
    logic [color_width-1:0] red;
    logic [color_width-1:0] green;
    logic [color_width-1:0] blue;
  } pixel_t;

  typedef struct packed {
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    pixel_t     color_a;
    pixel_t     color_b;
    logic [2:0] stripe_log2;
    logic       enable;
  } pattern_cfg_t;

  // One port per external SRAM, strobes active low
  typedef struct packed {
    logic [sram_addr_width-1:0] addr;
    pixel_t                     wdata;
    logic                       we_n;
    logic                       oe_n;
    logic                       ce_n;
  } sram_req_t;

  typedef struct packed {
    logic [color_width-1:0] red;
    logic [color_width-1:0] grn;
    logic [color_width-1:0] blu;
    logic                   hsync;
    logic                   vsync;
  } vga_out_t;

  typedef struct packed {
    logic                   valid;
    logic [index_width-1:0] index;
    pixel_t                 data;
  } fb_write_t;

endpackage

`default_nettype wire

// File: source/gfx_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_apb_regs (
  input  logic                  pixel_clk,
  input  logic                  reset,
  input  gfx_pkg::apb_req_t     apb_req,
  input  logic                  fill_done,
  input  logic                  error_set,
  output gfx_pkg::apb_rsp_t     apb_rsp,
  output gfx_pkg::pattern_cfg_t cfg,
  output logic                  restart,
  output logic                  error_clear
);
  import gfx_pkg::*;

  logic access;
  logic wr_en;
  logic addr_hit;
  logic status_err;

  assign access = apb_req.psel && apb_req.penable;  // Access phase
  assign wr_en = access && apb_req.pwrite;

  // Read mux and address decode
  always_comb begin
    addr_hit = 1'b1;
    apb_rsp.prdata = '0;
    case (apb_req.paddr)
      reg_ctrl:        apb_rsp.prdata = {31'b0, cfg.enable};
      reg_color_a:     apb_rsp.prdata = {{(32 - pixel_width){1'b0}}, cfg.color_a};
      reg_color_b:     apb_rsp.prdata = {{(32 - pixel_width){1'b0}}, cfg.color_b};
      reg_stripe_log2: apb_rsp.prdata = {29'b0, cfg.stripe_log2};
      reg_status:      apb_rsp.prdata = {30'b0, status_err, fill_done};
      default:         addr_hit = 1'b0;
    endcase
  end

  assign apb_rsp.pready = 1'b1;  // No wait states
  assign apb_rsp.pslverr = access && !addr_hit;

  // Any pattern register write starts the fill over
  assign restart = wr_en && addr_hit && (apb_req.paddr != reg_status);

  // Held while disabled so no error builds up before the first enable
  assign error_clear = !cfg.enable ||
                       (wr_en && (apb_req.paddr == reg_status) && apb_req.pwdata[1]);

  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (apb_req.paddr)
        reg_ctrl:        cfg.enable <= apb_req.pwdata[0];
        reg_color_a:     cfg.color_a <= apb_req.pwdata[pixel_width-1:0];
        reg_color_b:     cfg.color_b <= apb_req.pwdata[pixel_width-1:0];
        reg_stripe_log2: cfg.stripe_log2 <= apb_req.pwdata[2:0];
        default:         ;
      endcase
    end
  end

  // Sticky error, write 1 to clear
  always_ff @(posedge pixel_clk) begin
    if (reset || error_clear) begin
      status_err <= 1'b0;
    end else if (error_set) begin
      status_err <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/gfx_pattern_gen.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_pattern_gen (
  input  logic                  pixel_clk,
  input  logic                  reset,
  input  gfx_pkg::pattern_cfg_t cfg,
  input  logic                  restart,
  input  logic                  wr_ready,
  output gfx_pkg::fb_write_t    wr,
  output logic                  fill_done
);
  import gfx_pkg::*;

  logic [coord_width-1:0] x;
  logic [coord_width-1:0] y;
  logic [index_width-1:0] index;
  logic [coord_width:0]   diag;
  logic [coord_width:0]   band;
  logic                   last;

  // Diagonal stripes of width 2^stripe_log2
  assign diag = x + y;
  assign band = diag >> cfg.stripe_log2;

  assign wr.valid = cfg.enable && !fill_done;
  assign wr.index = index;
  assign wr.data = band[0] ? cfg.color_b : cfg.color_a;

  assign last = (index == index_width'(fb_words - 1));

  // ======================================================================
  // Framebuffer walker, advances on each accepted write
  // ======================================================================
  always_ff @(posedge pixel_clk) begin
    if (reset || restart) begin
      x <= '0;
      y <= '0;
      index <= '0;
      fill_done <= 1'b0;
    end else if (wr.valid && wr_ready) begin
      index <= index + 1'b1;
      if (last) begin
        fill_done <= 1'b1;
      end
      if (x == coord_width'(h_active - 1)) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/gfx_sram_stripe.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_sram_stripe (
  input  logic                                              pixel_clk,
  input  logic                                              reset,
  input  logic                                              rd_valid,
  input  logic [gfx_pkg::coord_width-1:0]                   rd_x,
  input  logic [gfx_pkg::coord_width-1:0]                   rd_y,
  input  gfx_pkg::fb_write_t                                wr,
  input  gfx_pkg::pixel_t [gfx_pkg::num_stripes-1:0]        sram_rdata,
  output logic                                              wr_ready,
  output gfx_pkg::sram_req_t [gfx_pkg::num_stripes-1:0]     sram,
  output gfx_pkg::pixel_t                                   rd_data
);
  import gfx_pkg::*;

  logic [index_width-1:0]     rd_index;
  logic [sram_addr_width-1:0] rd_addr;
  logic [sram_addr_width-1:0] wr_addr;
  logic                       rd_stripe;
  logic                       wr_stripe;
  logic                       wr_fire;

  assign rd_index = index_width'(rd_y * h_active + rd_x);

  // Even pixels in stripe 0, odd pixels in stripe 1
  assign rd_stripe = rd_index[0];
  assign wr_stripe = wr.index[0];
  assign rd_addr = sram_addr_width'(rd_index[index_width-1:1]);
  assign wr_addr = sram_addr_width'(wr.index[index_width-1:1]);

  // Display has priority, writer gets the idle stripe
  assign wr_ready = !rd_valid || (wr_stripe != rd_stripe);
  assign wr_fire = wr.valid && wr_ready;

  for (genvar s = 0; s < num_stripes; s++) begin : g_stripe
    logic rd_sel;
    logic wr_sel;

    assign rd_sel = rd_valid && (rd_stripe == 1'(s));
    assign wr_sel = wr_fire && (wr_stripe == 1'(s));

    assign sram[s].addr = rd_sel ? rd_addr : wr_addr;
    assign sram[s].wdata = wr.data;
    assign sram[s].oe_n = !rd_sel;
    assign sram[s].we_n = !wr_sel;
    assign sram[s].ce_n = !(rd_sel || wr_sel);
  end

  // Capture the data of the stripe just read
  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_valid) begin
      rd_data <= sram_rdata[rd_stripe];
    end
  end

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
  input  logic                            pixel_clk,
  input  logic                            reset,
  output logic [gfx_pkg::coord_width-1:0] x,
  output logic [gfx_pkg::coord_width-1:0] y,
  output logic                            active,
  output logic                            hsync,
  output logic                            vsync
);
  import gfx_pkg::*;

  logic [coord_width-1:0] h_count;
  logic [coord_width-1:0] v_count;
  logic                   h_last;
  logic                   v_last;
  logic                   h_in_sync;
  logic                   v_in_sync;

  assign h_last = (h_count == coord_width'(h_total - 1));
  assign v_last = (v_count == coord_width'(v_total - 1));

  assign h_in_sync = (h_count >= coord_width'(h_active + h_front)) &&
                     (h_count < coord_width'(h_active + h_front + h_sync));
  assign v_in_sync = (v_count >= coord_width'(v_active + v_front)) &&
                     (v_count < coord_width'(v_active + v_front + v_sync));

  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      h_count <= h_last ? '0 : h_count + 1'b1;
      if (h_last) begin
        v_count <= v_last ? '0 : v_count + 1'b1;
      end
    end
  end

  // Registered outputs, syncs active low
  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
      active <= 1'b0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      x <= h_count;
      y <= v_count;
      active <= (h_count < coord_width'(h_active)) && (v_count < coord_width'(v_active));
      hsync <= !h_in_sync;
      vsync <= !v_in_sync;
    end
  end

endmodule

`default_nettype wire

// File: source/gfx_display.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_display (
  input  logic              pixel_clk,
  input  logic              reset,
  input  logic              active,
  input  logic              hsync,
  input  logic              vsync,
  input  gfx_pkg::pixel_t   rd_data,
  input  logic              fill_done,
  input  logic              error_clear,
  output gfx_pkg::vga_out_t vga,
  output logic              vga_error,
  output logic              error_set
);

  logic active_d;
  logic hsync_d;
  logic vsync_d;

  // Showing a pixel the fill has not written yet
  assign error_set = active && !fill_done && !error_clear;

  // Stage 1 matches the SRAM read register
  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      active_d <= 1'b0;
      hsync_d <= 1'b1;
      vsync_d <= 1'b1;
    end else begin
      active_d <= active;
      hsync_d <= hsync;
      vsync_d <= vsync;
    end
  end

  // Stage 2 output register
  always_ff @(posedge pixel_clk) begin
    if (reset) begin
      vga <= '{red: '0, grn: '0, blu: '0, hsync: 1'b1, vsync: 1'b1};
    end else begin
      vga.red <= active_d ? rd_data.red : '0;  // Blank outside active area
      vga.grn <= active_d ? rd_data.green : '0;
      vga.blu <= active_d ? rd_data.blue : '0;
      vga.hsync <= hsync_d;
      vga.vsync <= vsync_d;
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (reset || error_clear) begin
      vga_error <= 1'b0;
    end else if (error_set) begin
      vga_error <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/gfx_demo_top.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_demo_top (
  input  logic                                          pixel_clk,
  input  logic                                          reset,
  input  gfx_pkg::apb_req_t                             apb_req,
  input  gfx_pkg::pixel_t [gfx_pkg::num_stripes-1:0]    sram_rdata,
  output gfx_pkg::apb_rsp_t                             apb_rsp,
  output gfx_pkg::vga_out_t                             vga,
  output logic                                          vga_error,
  output gfx_pkg::sram_req_t [gfx_pkg::num_stripes-1:0] sram
);
  import gfx_pkg::*;

  pattern_cfg_t           cfg;
  fb_write_t              wr;
  pixel_t                 rd_data;
  logic                   restart;
  logic                   error_clear;
  logic                   error_set;
  logic                   fill_done;
  logic                   wr_ready;
  logic [coord_width-1:0] x;
  logic [coord_width-1:0] y;
  logic                   active;
  logic                   hsync;
  logic                   vsync;

  // ======================================================================
  // Configuration and fill path
  // ======================================================================
  gfx_apb_regs i_regs (
    .pixel_clk   (pixel_clk),
    .reset       (reset),
    .apb_req     (apb_req),
    .fill_done   (fill_done),
    .error_set   (error_set),
    .apb_rsp     (apb_rsp),
    .cfg         (cfg),
    .restart     (restart),
    .error_clear (error_clear)
  );

  gfx_pattern_gen i_pattern (
    .pixel_clk (pixel_clk),
    .reset     (reset),
    .cfg       (cfg),
    .restart   (restart),
    .wr_ready  (wr_ready),
    .wr        (wr),
    .fill_done (fill_done)
  );

  gfx_sram_stripe i_stripe (
    .pixel_clk  (pixel_clk),
    .reset      (reset),
    .rd_valid   (active),
    .rd_x       (x),
    .rd_y       (y),
    .wr         (wr),
    .sram_rdata (sram_rdata),
    .wr_ready   (wr_ready),
    .sram       (sram),
    .rd_data    (rd_data)
  );

  // ======================================================================
  // Display path
  // ======================================================================
  vga_timing i_timing (
    .pixel_clk (pixel_clk),
    .reset     (reset),
    .x         (x),
    .y         (y),
    .active    (active),
    .hsync     (hsync),
    .vsync     (vsync)
  );

  gfx_display i_display (
    .pixel_clk   (pixel_clk),
    .reset       (reset),
    .active      (active),
    .hsync       (hsync),
    .vsync       (vsync),
    .rd_data     (rd_data),
    .fill_done   (fill_done),
    .error_clear (error_clear),
    .vga         (vga),
    .vga_error   (vga_error),
    .error_set   (error_set)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic pixel_clk,
  output logic reset
);

  // 25 MHz pixel clock, 40 ns period
  initial begin
    pixel_clk = 1'b0;
    forever #20 pixel_clk = ~pixel_clk;
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge pixel_clk);
    #5;
    reset = 1'b0;  // Released just after an edge
  end

endmodule

`default_nettype wire

// File: sim/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sram_model #(
  parameter int stripe = 0
) (
  input  logic               pixel_clk,
  input  gfx_pkg::sram_req_t req,
  output gfx_pkg::pixel_t    rdata
);
  import gfx_pkg::*;

  pixel_t mem [fb_words / num_stripes];

  // Power-up contents that differ per word and per stripe
  initial begin
    for (int i = 0; i < fb_words / num_stripes; i++) begin
      mem[i] = pixel_t'(12'(i ^ (i >> 9) ^ (stripe * 'h5a5)));
    end
  end

  // Read data follows the address while chip and output enables are low
  assign rdata = (!req.ce_n && !req.oe_n) ? mem[req.addr] : '0;

  // Write completes as we_n rises at the end of the pixel cycle
  always @(posedge pixel_clk) begin
    if (!req.ce_n && !req.we_n) begin
      mem[req.addr] <= req.wdata;
    end
  end

endmodule

`default_nettype wire

// File: sim/gfx_demo_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_demo_asserts (
  input logic                                          pixel_clk,
  input logic                                          reset,
  input logic                                          rd_valid,
  input logic [gfx_pkg::coord_width-1:0]               rd_x,
  input logic                                          wr_ready,
  input gfx_pkg::fb_write_t                            wr,
  input gfx_pkg::sram_req_t [gfx_pkg::num_stripes-1:0] sram
);
  import gfx_pkg::*;

  logic [num_stripes-1:0] both_low;
  logic                   read_stripe;
  int                     fail_count = 0;

  // Even line length makes x parity the stripe of the read pixel
  assign read_stripe = rd_x[0];

  for (genvar s = 0; s < num_stripes; s++) begin : g_stripe
    assign both_low[s] = !sram[s].we_n && !sram[s].oe_n;
  end

  a_strobes: assert property (@(posedge pixel_clk) disable iff (reset) both_low == '0)
    else begin
      $error("we_n and oe_n low together on one stripe");
      fail_count++;
    end

  // The stripe of the pixel on screen is read and never written
  a_stripes: assert property (@(posedge pixel_clk) disable iff (reset)
    rd_valid |-> (!sram[read_stripe].oe_n && sram[read_stripe].we_n))
    else begin
      $error("read and write on the same stripe in one cycle");
      fail_count++;
    end

  // Writer must wait while the display owns its stripe
  a_ready: assert property (@(posedge pixel_clk) disable iff (reset)
    (rd_valid && (wr.index[0] == read_stripe)) |-> !wr_ready)
    else begin
      $error("wr_ready high on the stripe being read");
      fail_count++;
    end

endmodule

bind gfx_sram_stripe gfx_demo_asserts i_asserts (
  .pixel_clk (pixel_clk),
  .reset     (reset),
  .rd_valid  (rd_valid),
  .rd_x      (rd_x),
  .wr_ready  (wr_ready),
  .wr        (wr),
  .sram      (sram)
);

`default_nettype wire

// File: sim/gfx_demo_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_demo_tb;
  import gfx_pkg::*;

  logic                        pixel_clk;
  logic                        reset;
  apb_req_t                    apb_req;
  apb_rsp_t                    apb_rsp;
  vga_out_t                    vga;
  logic                        vga_error;
  sram_req_t [num_stripes-1:0] sram;
  pixel_t [num_stripes-1:0]    sram_rdata;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  bit timed_out = 0;
  int cycle_count = 0;

  // Frame tracking, owned by the comparing process
  int   hpos = -1;
  int   vcnt = -1;
  int   frame_count = 0;
  int   check_done = 0;
  bit   in_window = 0;
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;

  // Expected configuration, owned by the tests
  int     check_req = 0;
  pixel_t exp_a;
  pixel_t exp_b;
  int     exp_log2;

  tb_clock i_clock (
    .pixel_clk (pixel_clk),
    .reset     (reset)
  );

  gfx_demo_top i_dut (
    .pixel_clk  (pixel_clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .sram_rdata (sram_rdata),
    .apb_rsp    (apb_rsp),
    .vga        (vga),
    .vga_error  (vga_error),
    .sram       (sram)
  );

  sram_model #(.stripe(0)) i_sram0 (
    .pixel_clk (pixel_clk),
    .req       (sram[0]),
    .rdata     (sram_rdata[0])
  );

  sram_model #(.stripe(1)) i_sram1 (
    .pixel_clk (pixel_clk),
    .req       (sram[1]),
    .rdata     (sram_rdata[1])
  );

  always @(posedge pixel_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // ====================================================================
  // Checking helpers
  // ====================================================================
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      if (errors <= 20) begin
        $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    timed_out = 1;
  endtask

  task automatic end_test(input string name, input int first_err);
    tests++;
    if (errors == first_err && !timed_out) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests, name, errors - first_err);
    end
  endtask

  // Diagonal stripe rule
  function automatic pixel_t ref_pixel(input int px, input int py, input pixel_t a,
                                       input pixel_t b, input int log2);
    int band;
    band = (px + py) >> log2;
    if (band[0]) begin
      return b;
    end
    return a;
  endfunction

  // ====================================================================
  // Comparing process, locates pixels from the output syncs
  // ====================================================================
  always @(negedge pixel_clk) begin : compare
    int     px;
    int     py;
    pixel_t expected;
    if (reset) begin
      hpos = -1;
      vcnt = -1;
      in_window = 0;
      prev_hs = 1'b1;
      prev_vs = 1'b1;
    end else begin
      if (!prev_hs && vga.hsync) begin
        hpos = 0;
        if (vcnt >= 0) begin
          vcnt++;  // Lines since vsync rose
        end
      end else if (hpos >= 0) begin
        hpos++;
      end
      if (!prev_vs && vga.vsync) begin
        vcnt = 0;
        frame_count++;
        if (in_window) begin
          in_window = 0;
          check_done++;
        end else if (check_req != check_done) begin
          in_window = 1;
        end
      end
      if (in_window && hpos >= 0) begin
        px = hpos - h_back;
        py = vcnt - v_back;
        if (px >= 0 && px < h_active && py >= 0 && py < v_active) begin
          expected = ref_pixel(px, py, exp_a, exp_b, exp_log2);
        end else begin
          expected = '0;
        end
        check_value("vga colour", 32'({vga.red, vga.grn, vga.blu}), 32'(expected));
      end
      prev_hs = vga.hsync;
      prev_vs = vga.vsync;
    end
  end

  // ====================================================================
  // APB master and waits
  // ====================================================================
  task automatic apb_access(input logic [7:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    int waited;
    waited = 0;
    @(posedge pixel_clk);
    #5;
    apb_req.paddr = addr;
    apb_req.pwrite = write;
    apb_req.pwdata = wdata;
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge pixel_clk);
    #5;
    apb_req.penable = 1'b1;
    @(negedge pixel_clk);
    while (apb_rsp.pready !== 1'b1 && waited < 16) begin
      @(negedge pixel_clk);
      waited++;
    end
    if (apb_rsp.pready !== 1'b1) begin
      report_timeout("APB pready");
    end
    rdata = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge pixel_clk);
    #5;
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(addr, 1'b1, wdata, rdata, slverr);
    check_value("pslverr on write", 32'(slverr), 0);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_access(addr, 1'b0, 0, rdata, slverr);
    check_value("pslverr on read", 32'(slverr), 0);
  endtask

  task automatic poll_status(input int bit_pos, input logic level, input int limit);
    logic [31:0] rdata;
    int          start;
    if (timed_out) return;
    start = cycle_count;
    apb_read(reg_status, rdata);
    while (rdata[bit_pos] !== level && cycle_count - start < limit) begin
      apb_read(reg_status, rdata);
    end
    if (rdata[bit_pos] !== level) begin
      report_timeout($sformatf("status bit %0d to become %0d", bit_pos, level));
    end
  endtask

  task automatic wait_level(input bit use_vsync, input logic level, input int limit,
                            output int cycles);
    logic value;
    cycles = 0;
    value = ~level;
    if (timed_out) return;
    do begin
      @(negedge pixel_clk);
      cycles++;
      value = use_vsync ? vga.vsync : vga.hsync;
    end while (value !== level && cycles < limit);
    if (value !== level) begin
      report_timeout(use_vsync ? "a vsync edge" : "an hsync edge");
    end
  endtask

  task automatic wait_frames(input int n);
    int start;
    int waited;
    if (timed_out) return;
    start = frame_count;
    waited = 0;
    while (frame_count - start < n && waited < (n + 1) * h_total * v_total) begin
      @(posedge pixel_clk);
      waited++;
    end
    if (frame_count - start < n) begin
      report_timeout("the next frame");
    end
  endtask

  task automatic check_frame(input pixel_t a, input pixel_t b, input int log2);
    int waited;
    if (timed_out) return;
    exp_a = a;
    exp_b = b;
    exp_log2 = log2;
    check_req++;
    waited = 0;
    while (check_done != check_req && waited < 3 * h_total * v_total) begin
      @(posedge pixel_clk);
      waited++;
    end
    if (check_done != check_req) begin
      report_timeout("a compared frame");
    end
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  initial begin : main
    logic [31:0] rdata;
    logic        slverr;
    pixel_t      color_a;
    pixel_t      color_b;
    int          log2;
    int          waited;
    int          low;
    int          high;
    int          first_err;
    apb_req = '0;
    void'($urandom(46));

    waited = 0;
    @(negedge pixel_clk);
    while (reset && waited < 100) begin
      @(negedge pixel_clk);
      waited++;
    end
    if (reset) begin
      report_timeout("reset release");
    end

    // Still the reset state, no clock edge since release
    first_err = errors;
    check_value("hsync after reset", 32'(vga.hsync), 1);
    check_value("vsync after reset", 32'(vga.vsync), 1);
    check_value("colour after reset", 32'({vga.red, vga.grn, vga.blu}), 0);
    check_value("vga_error after reset", 32'(vga_error), 0);
    check_value("stripe 0 strobes", 32'({sram[0].we_n, sram[0].oe_n, sram[0].ce_n}), 7);
    check_value("stripe 1 strobes", 32'({sram[1].we_n, sram[1].oe_n, sram[1].ce_n}), 7);
    apb_read(reg_status, rdata);
    check_value("status after reset", rdata, 0);
    end_test("reset state", first_err);

    first_err = errors;
    apb_access(8'h14, 1'b0, 0, rdata, slverr);
    check_value("pslverr on unmapped read", 32'(slverr), 1);
    apb_access(8'h20, 1'b1, 32'h5a5, rdata, slverr);
    check_value("pslverr on unmapped write", 32'(slverr), 1);
    color_a = pixel_t'(12'($urandom));
    color_b = pixel_t'(12'($urandom));
    log2 = int'($urandom % 8);
    apb_write(reg_color_a, 32'(color_a));
    apb_write(reg_color_b, 32'(color_b));
    apb_write(reg_stripe_log2, log2);
    apb_read(reg_color_a, rdata);
    check_value("color_a readback", rdata, 32'(color_a));
    apb_read(reg_color_b, rdata);
    check_value("color_b readback", rdata, 32'(color_b));
    apb_read(reg_stripe_log2, rdata);
    check_value("stripe_log2 readback", rdata, log2);
    apb_read(reg_ctrl, rdata);
    check_value("ctrl readback", rdata, 0);
    end_test("register access", first_err);

    first_err = errors;
    color_a = pixel_t'(12'($urandom));
    color_b = pixel_t'(12'($urandom));
    if (color_b == color_a) begin
      color_b = ~color_a;
    end
    log2 = int'($urandom % 8);
    apb_write(reg_color_a, 32'(color_a));
    apb_write(reg_color_b, 32'(color_b));
    apb_write(reg_stripe_log2, log2);
    apb_write(reg_ctrl, 1);
    poll_status(0, 1'b1, 2 * h_total * v_total);
    check_frame(color_a, color_b, log2);
    end_test("fill and frame", first_err);

    first_err = errors;
    wait_level(0, 1'b1, 2 * h_total, low);
    wait_level(0, 1'b0, 2 * h_total, low);
    wait_level(0, 1'b1, 2 * h_total, low);
    wait_level(0, 1'b0, 2 * h_total, high);
    check_value("hsync width", low, h_sync);
    check_value("line length", low + high, h_total);
    wait_level(1, 1'b1, 2 * h_total * v_total, low);
    wait_level(1, 1'b0, 2 * h_total * v_total, low);
    wait_level(1, 1'b1, 2 * h_total * v_total, low);
    wait_level(1, 1'b0, 2 * h_total * v_total, high);
    check_value("vsync width", low, v_sync * h_total);
    check_value("frame length", low + high, v_total * h_total);
    end_test("sync timing", first_err);

    // Fill from scratch while the display runs
    first_err = errors;
    apb_write(reg_ctrl, 0);
    apb_write(reg_ctrl, 1);
    poll_status(1, 1'b1, h_total * v_total);
    poll_status(0, 1'b1, 2 * h_total * v_total);
    apb_write(reg_status, 2);
    apb_read(reg_status, rdata);
    check_value("status after clear", rdata, 1);
    wait_frames(2);
    apb_read(reg_status, rdata);
    check_value("status a frame later", rdata, 1);
    check_value("vga_error a frame later", 32'(vga_error), 0);
    end_test("error flag", first_err);

    first_err = errors;
    color_b = pixel_t'(12'($urandom));
    if (color_b == color_a) begin
      color_b = ~color_a;
    end
    log2 = (log2 + 1 + int'($urandom % 7)) % 8;
    apb_write(reg_color_b, 32'(color_b));
    apb_read(reg_status, rdata);
    check_value("fill_done after restart", 32'(rdata[0]), 0);
    apb_write(reg_stripe_log2, log2);
    poll_status(0, 1'b1, 2 * h_total * v_total);
    check_frame(color_a, color_b, log2);
    end_test("reconfigure", first_err);

    errors += i_dut.i_stripe.i_asserts.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures, timeout %0d",
             tests, checks, errors, i_dut.i_stripe.i_asserts.fail_count, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/gfx_pkg.sv
source/gfx_apb_regs.sv
source/gfx_pattern_gen.sv
source/gfx_sram_stripe.sv
source/vga_timing.sv
source/gfx_display.sv
source/gfx_demo_top.sv
sim/tb_clock.sv
sim/sram_model.sv
sim/gfx_demo_asserts.sv
sim/gfx_demo_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module gfx_demo_tb
out=$(./obj_dir/Vgfx_demo_tb +verilator+error+limit+1000) || true
echo "$out"
echo "$out" | grep -qx "Result: PASSED"
